// File: files.f
+incdir+bench
hdl/rvc_pkg.sv
hdl/rvc_quadrant0.sv
hdl/rvc_quadrant1.sv
hdl/rvc_quadrant2.sv
hdl/rvc_decompressor.sv
bench/tb_rvc_decompressor.sv

// File: Makefile
# Verilator build for the RV32C decompressor testbench

TOP := tb_rvc_decompressor

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing -f files.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir

// File: bench/tb_rvc_ref.svh
// Reference RV32C expansion and Galois LFSR for the testbench
// Expects LFSR_TAPS declared in the including module
// Float and reserved slots leave the expansion word at zero

`ifndef TB_RVC_REF_SVH
`define TB_RVC_REF_SVH

// ========================================
// RV32 base format encoders
// ========================================
function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  enc_i = {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
  enc_s = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // SW only
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  enc_r = {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

// Branch against x0, offset bit 0 dropped
function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs1,
                                      input logic [2:0] f3);
  enc_b = {off[12], off[10:5], 5'd0, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
  enc_j = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

// ========================================
// Reference model
// ========================================
function automatic rvc_pkg::rvc_out_t ref_expand(input logic [15:0] p);
  rvc_pkg::rvc_out_t r;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [4:0]  rdp;    // x8..x15 from bits 4:2
  logic [4:0]  rsp;    // x8..x15 from bits 9:7
  logic [11:0] ci;     // Sign-extended 6-bit imm
  logic [11:0] o;
  logic [8:0]  bo;
  logic [9:0]  n;
  rd  = p[11:7];
  rs2 = p[6:2];
  rdp = {2'b01, p[4:2]};
  rsp = {2'b01, p[9:7]};
  ci  = {{7{p[12]}}, p[6:2]};
  o   = {p[12], p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0};
  bo  = {p[12], p[6:5], p[2], p[11:10], p[4:3], 1'b0};
  n   = {p[12], p[4:3], p[5], p[2], p[6], 4'b0};
  r.instr         = '0;
  r.is_compressed = 1'b1;
  r.illegal       = 1'b0;
  case ({p[1:0], p[15:13]})
    5'b00_000: begin  // ADDI4SPN
      r.instr   = enc_i({2'b0, p[10:7], p[12:11], p[5], p[6], 2'b0}, 5'd2, 3'b000, rdp,
                        7'b0010011);
      r.illegal = (p[12:5] == 8'd0);
    end
    5'b00_010: r.instr = enc_i({5'b0, p[5], p[12:10], p[6], 2'b0}, rsp, 3'b010, rdp,
                               7'b0000011);
    5'b00_110: r.instr = enc_s({5'b0, p[5], p[12:10], p[6], 2'b0}, rdp, rsp);
    5'b01_000: r.instr = enc_i(ci, rd, 3'b000, rd, 7'b0010011);
    5'b01_001: r.instr = enc_j({{9{o[11]}}, o}, 5'd1);
    5'b01_010: r.instr = enc_i(ci, 5'd0, 3'b000, rd, 7'b0010011);
    5'b01_011: begin
      if (rd == 5'd2) begin  // ADDI16SP
        r.instr   = enc_i({{2{n[9]}}, n}, 5'd2, 3'b000, 5'd2, 7'b0010011);
        r.illegal = (n == 10'd0);
      end else begin
        r.instr   = {{14{p[12]}}, p[12], p[6:2], rd, 7'b0110111};
        r.illegal = (rd == 5'd0) || ({p[12], p[6:2]} == 6'd0);
      end
    end
    5'b01_100: begin
      case (p[11:10])
        2'b00: r.instr = enc_i({7'b0000000, rs2}, rsp, 3'b101, rsp, 7'b0010011);
        2'b01: r.instr = enc_i({7'b0100000, rs2}, rsp, 3'b101, rsp, 7'b0010011);
        2'b10: r.instr = enc_i(ci, rsp, 3'b111, rsp, 7'b0010011);
        default: begin
          case (p[6:5])
            2'b00:   r.instr = enc_r(7'b0100000, rdp, rsp, 3'b000, rsp);
            2'b01:   r.instr = enc_r(7'b0000000, rdp, rsp, 3'b100, rsp);
            2'b10:   r.instr = enc_r(7'b0000000, rdp, rsp, 3'b110, rsp);
            default: r.instr = enc_r(7'b0000000, rdp, rsp, 3'b111, rsp);
          endcase
        end
      endcase
      r.illegal = p[12] && (p[11:10] != 2'b10);  // shamt[5] or SUBW/ADDW
    end
    5'b01_101: r.instr = enc_j({{9{o[11]}}, o}, 5'd0);
    5'b01_110: r.instr = enc_b({{4{bo[8]}}, bo}, rsp, 3'b000);
    5'b01_111: r.instr = enc_b({{4{bo[8]}}, bo}, rsp, 3'b001);
    5'b10_000: begin
      r.instr   = enc_i({7'b0, rs2}, rd, 3'b001, rd, 7'b0010011);
      r.illegal = p[12] || (rd == 5'd0);
    end
    5'b10_010: begin
      r.instr   = enc_i({4'b0, p[3:2], p[12], p[6:4], 2'b0}, 5'd2, 3'b010, rd, 7'b0000011);
      r.illegal = (rd == 5'd0);
    end
    5'b10_100: begin
      if (!p[12] && rs2 == 5'd0) r.instr = enc_i(12'd0, rd, 3'b000, 5'd0, 7'b1100111);
      else if (!p[12])           r.instr = enc_r(7'b0, rs2, 5'd0, 3'b000, rd);
      else if (rs2 != 5'd0)      r.instr = enc_r(7'b0, rs2, rd, 3'b000, rd);
      else if (rd == 5'd0)       r.instr = 32'h0010_0073;  // EBREAK
      else                       r.instr = enc_i(12'd0, rd, 3'b000, 5'd1, 7'b1100111);
      r.illegal = (rd == 5'd0) && !(p[12] && rs2 == 5'd0);
    end
    5'b10_110: r.instr = enc_s({4'b0, p[8:7], p[12:9], 2'b0}, rs2, 5'd2);
    5'b11_000, 5'b11_001, 5'b11_010, 5'b11_011,
    5'b11_100, 5'b11_101, 5'b11_110, 5'b11_111: begin
      r.instr         = {16'b0, p};
      r.is_compressed = 1'b0;
    end
    default: r.illegal = 1'b1;  // Float and reserved slots
  endcase
  return r;
endfunction

// Next Galois state, output bit is the old bit 0
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  lfsr_next = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
endfunction

`endif

// File: bench/tb_rvc_decompressor.sv
// Testbench for the RV32C decompressor
// Expected words come from ref_expand, checked in output order
// Runs directed parcels first, then LFSR traffic with random back-pressure

`timescale 1ns/10ps

module tb_rvc_decompressor;

  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32+x^22+x^2+x+1
  localparam logic [31:0] LFSR_SEED = 32'd1;
  localparam int          N_RANDOM  = 4000;
  localparam int          WAIT_MAX  = 50;             // Cycles per single wait

  `include "tb_rvc_ref.svh"

  logic                 i_clk;
  logic                 i_arst_n;
  logic                 i_valid;
  logic                 o_ready;
  rvc_pkg::rvc_parcel_t i_parcel;
  logic                 o_valid;
  logic                 i_ready;
  rvc_pkg::rvc_out_t    o_result;

  rvc_pkg::rvc_out_t    exp_q[$];   // Scoreboard, one entry per accepted parcel
  rvc_pkg::rvc_out_t    held;       // Result seen under back-pressure
  logic                 hold_chk;
  logic [31:0]          lfsr_state;
  int                   errors;
  int                   timeouts;
  int                   popped;

  rvc_decompressor u_rvc_decompressor (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (i_valid),
    .o_ready  (o_ready),
    .i_parcel (i_parcel),
    .o_valid  (o_valid),
    .i_ready  (i_ready),
    .o_result (o_result)
  );

  always #50 i_clk = ~i_clk;  // 100 ns period

  // Takes one LFSR bit per call
  function automatic logic take_bit();
    logic b;
    b          = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
    return b;
  endfunction

  function automatic logic [15:0] take_parcel();
    logic [15:0] v;
    for (int i = 0; i < 16; i++) begin
      v[i] = take_bit();
    end
    return v;
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED t=%0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ========================================
  // Scoreboard and hold monitor
  // ========================================
  always @(posedge i_clk) begin
    rvc_pkg::rvc_out_t e;
    if (hold_chk && i_arst_n) begin
      check(64'(o_valid), 64'(1'b1), "o_valid dropped under back-pressure");
      check(64'(o_result), 64'(held), "o_result changed under back-pressure");
    end
    hold_chk = o_valid && !i_ready;
    held     = o_result;
    if (o_valid && i_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Output handshake at %0t with no parcel outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        popped++;
        check(64'(o_result.is_compressed), 64'(e.is_compressed), "is_compressed");
        check(64'(o_result.illegal), 64'(e.illegal),
              $sformatf("illegal, expected word %h", e.instr));
        if (!e.illegal) begin
          check(64'(o_result.instr), 64'(e.instr), "expansion");
        end
      end
    end
    if (i_valid && o_ready && i_arst_n) begin
      exp_q.push_back(ref_expand(i_parcel));
    end
  end

  // Directed parcel, waits for acceptance and checks the one-cycle latency
  task automatic send(input logic [15:0] p);
    int n;
    @(negedge i_clk);
    i_valid  = 1'b1;
    i_parcel = p;
    n = 0;
    while (!o_ready && n < WAIT_MAX) begin
      @(negedge i_clk);
      n++;
    end
    if (n >= WAIT_MAX) begin
      timeouts++;
      $display("Timed out waiting for o_ready on parcel %h", p);
    end
    @(negedge i_clk);
    i_valid = 1'b0;
    check(64'(o_valid), 64'(1'b1), $sformatf("o_valid one cycle after parcel %h", p));
  endtask

  initial begin
    logic [15:0] dir[$];
    int          sent;
    int          n;
    logic        fired;
    i_clk      = 1'b0;
    i_arst_n   = 1'b0;
    i_valid    = 1'b0;
    i_ready    = 1'b0;  // o_ready must then come from the empty register
    i_parcel   = '0;
    lfsr_state = LFSR_SEED;
    errors     = 0;
    timeouts   = 0;
    popped     = 0;
    hold_chk   = 1'b0;
    for (int i = 0; i < 16; i++) begin
      @(negedge i_clk);
      check(64'({o_valid, o_ready}), 64'(2'b01), "o_valid/o_ready in reset");
    end
    i_arst_n = 1'b1;
    @(negedge i_clk);
    check(64'({o_valid, o_ready}), 64'(2'b01), "o_valid/o_ready after reset");
    i_ready = 1'b1;

    // Legal forms, then illegal forms, then quadrant 3
    dir = '{16'h0040, 16'h43D8, 16'hC3D8, 16'h0505, 16'h0001, 16'h3FFD, 16'h4505,
            16'h6105, 16'h6505, 16'h8085, 16'h8485, 16'h8885, 16'h8C85, 16'h8CA5,
            16'h8CC5, 16'h8CE5, 16'hBFF5, 16'hC081, 16'hE081, 16'hD0FD, 16'h050A,
            16'h4502, 16'h8502, 16'h852E, 16'h9002, 16'h9502, 16'h952E, 16'hC42E,
            16'h0000, 16'h2000, 16'h8000, 16'h6101, 16'h6005, 16'h6501, 16'h9085,
            16'h9485, 16'h9C85, 16'h9CA5, 16'h150A, 16'h000A, 16'h4002, 16'h8002,
            16'h802E, 16'h902E, 16'h2002, 16'h6002, 16'hA002, 16'hE002,
            16'h0003, 16'hFFFF, 16'h1237};
    foreach (dir[i]) begin
      send(dir[i]);
    end

    // ========================================
    // LFSR traffic with random back-pressure
    // ========================================
    @(negedge i_clk);
    i_valid  = 1'b1;
    i_parcel = take_parcel();
    sent = 0;
    n = 0;
    while (sent < N_RANDOM && n < N_RANDOM * 20) begin
      i_ready = take_bit();
      @(posedge i_clk);
      fired = i_valid && o_ready;
      @(negedge i_clk);
      n++;
      if (fired) begin
        sent++;
        i_parcel = take_parcel();
      end
    end
    if (sent < N_RANDOM) begin
      timeouts++;
      $display("Random traffic stalled after %0d parcels", sent);
    end
    i_valid = 1'b0;
    i_ready = 1'b1;
    n = 0;
    while ((exp_q.size() != 0 || o_valid) && n < WAIT_MAX) begin
      @(negedge i_clk);
      n++;
    end
    if (n >= WAIT_MAX) begin
      timeouts++;
      $display("Timed out draining, %0d results still outstanding", exp_q.size());
    end

    $display("Results checked: %0d, errors: %0d, timeouts: %0d", popped, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : tb_rvc_decompressor

// File: hdl/rvc_decompressor.sv
// RV32C decompressor with one registered valid/ready output stage
// Latency is one cycle, throughput one parcel per cycle
// o_result is only meaningful while o_valid is high

`timescale 1ns/10ps

module rvc_decompressor (
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic                 i_valid,   // Parcel offered
  output logic                 o_ready,   // Stage can take a parcel
  input  rvc_pkg::rvc_parcel_t i_parcel,
  output logic                 o_valid,   // Result held in register
  input  logic                 i_ready,   // Sink takes the result
  output rvc_pkg::rvc_out_t    o_result
);

  // ======================================
  // Quadrant decoders, all run in parallel
  // ======================================
  rvc_pkg::rvc_exp_t q0_exp;
  rvc_pkg::rvc_exp_t q1_exp;
  rvc_pkg::rvc_exp_t q2_exp;
  rvc_pkg::rvc_out_t next_result;
  logic              load;  // Input handshake this cycle

  rvc_quadrant0 u_quadrant0 (
    .i_parcel (i_parcel),
    .o_exp    (q0_exp)
  );

  rvc_quadrant1 u_quadrant1 (
    .i_parcel (i_parcel),
    .o_exp    (q1_exp)
  );

  rvc_quadrant2 u_quadrant2 (
    .i_parcel (i_parcel),
    .o_exp    (q2_exp)
  );

  // Pick by quadrant, bits 1:0 are the only thing tested here
  always_comb begin
    next_result.is_compressed = 1'b1;
    case (i_parcel[1:0])
      rvc_pkg::QUAD_C0: {next_result.instr, next_result.illegal} = q0_exp;
      rvc_pkg::QUAD_C1: {next_result.instr, next_result.illegal} = q1_exp;
      rvc_pkg::QUAD_C2: {next_result.instr, next_result.illegal} = q2_exp;
      default: begin
        // QUAD_FULL, low half of a 32-bit instruction
        next_result.instr         = {16'b0, i_parcel};
        next_result.is_compressed = 1'b0;
        next_result.illegal       = 1'b0;
      end
    endcase
  end

  // ======================================
  // Output register stage
  // ======================================

  // Empty, or draining this same cycle
  assign o_ready = !o_valid || i_ready;
  assign load    = i_valid && o_ready;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
    end else if (load) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;  // Drained, nothing new behind it
    end
  end

  // Data only moves on a load, held under back-pressure
  always_ff @(posedge i_clk) begin
    if (load) begin
      o_result <= next_result;
    end
  end

endmodule : rvc_decompressor

// File: hdl/rvc_quadrant2.sv
// Quadrant-2 expander, combinational
// Assumes parcel bits 1:0 are already known to be 10
// Float loads/stores and HINT forms with rd=0 are reported illegal

`timescale 1ns/10ps

module rvc_quadrant2 (
  input  rvc_pkg::rvc_parcel_t i_parcel,
  output rvc_pkg::rvc_exp_t    o_exp
);

  rvc_pkg::rv_funct3_t funct3;
  rvc_pkg::rv_reg_t    rd;         // Also rs1 of JR/JALR/ADD
  rvc_pkg::rv_reg_t    rs2;        // Also shamt of SLLI
  logic                rd_zero;
  logic                rs2_zero;
  rvc_pkg::rv_imm12_t  imm_lwsp;   // uimm scaled by 4
  rvc_pkg::rv_imm12_t  imm_swsp;   // uimm scaled by 4

  assign funct3   = i_parcel[15:13];
  assign rd       = i_parcel[11:7];
  assign rs2      = i_parcel[6:2];
  assign rd_zero  = (rd == rvc_pkg::REG_ZERO);
  assign rs2_zero = (rs2 == rvc_pkg::REG_ZERO);

  // uimm[5] in 12, uimm[4:2|7:6] in 6:2
  assign imm_lwsp = {4'b0, i_parcel[3:2], i_parcel[12], i_parcel[6:4], 2'b00};

  // uimm[5:2|7:6] in 12:7
  assign imm_swsp = {4'b0, i_parcel[8:7], i_parcel[12:9], 2'b00};

  // ======================================
  // Expansion
  // ======================================
  always_comb begin
    o_exp.instr   = '0;
    o_exp.illegal = 1'b0;
    case (funct3)
      3'b000: begin  // C.SLLI
        o_exp.instr = {7'b0000000, rs2, rd, 3'b001, rd, rvc_pkg::OPC_OP_IMM};
        o_exp.illegal = i_parcel[12] || rd_zero;  // shamt[5] or HINT
      end
      3'b010: begin  // C.LWSP
        o_exp.instr = {imm_lwsp, rvc_pkg::REG_SP, 3'b010, rd, rvc_pkg::OPC_LOAD};
        o_exp.illegal = rd_zero;
      end
      3'b100: begin
        if (!i_parcel[12]) begin
          if (rs2_zero) begin  // C.JR
            o_exp.instr = {12'b0, rd, 3'b000, rvc_pkg::REG_ZERO, rvc_pkg::OPC_JALR};
          end else begin  // C.MV as ADD from x0
            o_exp.instr = {7'b0, rs2, rvc_pkg::REG_ZERO, 3'b000, rd, rvc_pkg::OPC_OP};
          end
          // JR x0 reserved, MV to x0 is a HINT
          o_exp.illegal = rd_zero;
        end else if (rs2_zero) begin
          if (rd_zero) begin
            o_exp.instr = rvc_pkg::INSTR_EBREAK;  // C.EBREAK
          end else begin  // C.JALR links to ra
            o_exp.instr = {12'b0, rd, 3'b000, rvc_pkg::REG_RA, rvc_pkg::OPC_JALR};
          end
        end else begin  // C.ADD
          o_exp.instr = {7'b0, rs2, rd, 3'b000, rd, rvc_pkg::OPC_OP};
          o_exp.illegal = rd_zero;
        end
      end
      3'b110: begin  // C.SWSP, offset split S-type style
        o_exp.instr = {imm_swsp[11:5], rs2, rvc_pkg::REG_SP, 3'b010,
                       imm_swsp[4:0], rvc_pkg::OPC_STORE};
      end
      default: begin
        // FLDSP/FLWSP/FSDSP/FSWSP not supported
        o_exp.illegal = 1'b1;
      end
    endcase
  end

endmodule : rvc_quadrant2

// File: hdl/rvc_quadrant1.sv
// Quadrant-1 expander, combinational
// Assumes parcel bits 1:0 are already known to be 01
// RV32 only, so shamt[5] and the SUBW/ADDW slots are illegal

`timescale 1ns/10ps

module rvc_quadrant1 (
  input  rvc_pkg::rvc_parcel_t i_parcel,
  output rvc_pkg::rvc_exp_t    o_exp
);

  // ======================================
  // Field extraction
  // ======================================
  rvc_pkg::rv_funct3_t funct3;
  rvc_pkg::rv_reg_t    rd;       // Full rd/rs1, bits 11:7
  rvc_pkg::rv_reg_t    rs1_p;    // rs1'/rd' of the ALU group
  rvc_pkg::rv_reg_t    rs2_p;
  rvc_pkg::rv_reg_t    shamt;    // RV32 shift amount
  logic [1:0]          alu_grp;  // Bits 11:10 of funct3=100
  logic [1:0]          alu_op;   // Bits 6:5 of the reg-reg ops
  logic [5:0]          imm6;     // Raw CI immediate

  assign funct3  = i_parcel[15:13];
  assign rd      = i_parcel[11:7];
  assign rs1_p   = {2'b01, i_parcel[9:7]};
  assign rs2_p   = {2'b01, i_parcel[4:2]};
  assign shamt   = i_parcel[6:2];
  assign alu_grp = i_parcel[11:10];
  assign alu_op  = i_parcel[6:5];
  assign imm6    = {i_parcel[12], i_parcel[6:2]};

  // ======================================
  // Immediates
  // ======================================
  rvc_pkg::rv_imm12_t imm_ci;    // ADDI/LI/ANDI
  rvc_pkg::rv_imm12_t imm_16sp;  // nzimm scaled by 16
  logic [19:0]        imm_lui;   // U-type upper field
  logic [11:0]        imm_j;     // Jump offset, bit 0 always zero
  logic [8:0]         imm_b;     // Branch offset, bit 0 always zero

  assign imm_ci = {{6{imm6[5]}}, imm6};

  // nzimm[9|4|6|8:7|5] from 12, 6, 5, 4:3, 2
  assign imm_16sp = {{3{i_parcel[12]}}, i_parcel[4:3], i_parcel[5],
                     i_parcel[2], i_parcel[6], 4'b0000};

  assign imm_lui = {{14{imm6[5]}}, imm6};

  // offset[11|4|9:8|10|6|7|3:1|5] scattered over 12:2
  assign imm_j = {i_parcel[12], i_parcel[8], i_parcel[10:9], i_parcel[6],
                  i_parcel[7], i_parcel[2], i_parcel[11], i_parcel[5:3], 1'b0};

  // offset[8|4:3] in 12:10, offset[7:6|2:1|5] in 6:2
  assign imm_b = {i_parcel[12], i_parcel[6:5], i_parcel[2],
                  i_parcel[11:10], i_parcel[4:3], 1'b0};

  // ======================================
  // Expansion
  // ======================================
  rvc_pkg::rv_instr_t jal_word;  // C.J and C.JAL differ only in rd
  rvc_pkg::rv_instr_t br_word;   // C.BEQZ and C.BNEZ differ only in funct3

  // J-type, imm[20|10:1|11|19:12]
  assign jal_word = {imm_j[11], imm_j[10:1], imm_j[11], {8{imm_j[11]}},
                     rvc_pkg::REG_ZERO, rvc_pkg::OPC_JAL};

  // B-type, imm[12|10:5] rs2 rs1 f3 imm[4:1|11]
  assign br_word = {imm_b[8], {3{imm_b[8]}}, imm_b[7:5], rvc_pkg::REG_ZERO, rs1_p,
                    3'b000, imm_b[4:1], imm_b[8], rvc_pkg::OPC_BRANCH};

  always_comb begin
    o_exp.instr   = '0;
    o_exp.illegal = 1'b0;
    case (funct3)
      3'b000: begin  // C.ADDI, C.NOP when rd=0
        o_exp.instr = {imm_ci, rd, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
      end
      3'b001: begin  // C.JAL links to ra
        o_exp.instr = jal_word;
        o_exp.instr[11:7] = rvc_pkg::REG_RA;
      end
      3'b010: begin  // C.LI as ADDI from x0
        o_exp.instr = {imm_ci, rvc_pkg::REG_ZERO, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
      end
      3'b011: begin
        if (rd == rvc_pkg::REG_SP) begin  // C.ADDI16SP
          o_exp.instr = {imm_16sp, rvc_pkg::REG_SP, 3'b000, rvc_pkg::REG_SP,
                         rvc_pkg::OPC_OP_IMM};
          o_exp.illegal = (imm_16sp == '0);
        end else begin  // C.LUI
          o_exp.instr = {imm_lui, rd, rvc_pkg::OPC_LUI};
          o_exp.illegal = (rd == rvc_pkg::REG_ZERO) || (imm6 == '0);
        end
      end
      3'b100: begin
        case (alu_grp)
          2'b00: begin  // C.SRLI
            o_exp.instr = {7'b0000000, shamt, rs1_p, 3'b101, rs1_p, rvc_pkg::OPC_OP_IMM};
            o_exp.illegal = i_parcel[12];  // shamt[5] needs RV64
          end
          2'b01: begin  // C.SRAI
            o_exp.instr = {7'b0100000, shamt, rs1_p, 3'b101, rs1_p, rvc_pkg::OPC_OP_IMM};
            o_exp.illegal = i_parcel[12];
          end
          2'b10: begin  // C.ANDI
            o_exp.instr = {imm_ci, rs1_p, 3'b111, rs1_p, rvc_pkg::OPC_OP_IMM};
          end
          default: begin
            // Bit 12 set selects SUBW/ADDW, RV64 only
            o_exp.illegal = i_parcel[12];
            case (alu_op)
              2'b00: o_exp.instr = {7'b0100000, rs2_p, rs1_p, 3'b000, rs1_p,
                                    rvc_pkg::OPC_OP};  // C.SUB
              2'b01: o_exp.instr = {7'b0000000, rs2_p, rs1_p, 3'b100, rs1_p,
                                    rvc_pkg::OPC_OP};  // C.XOR
              2'b10: o_exp.instr = {7'b0000000, rs2_p, rs1_p, 3'b110, rs1_p,
                                    rvc_pkg::OPC_OP};  // C.OR
              default: o_exp.instr = {7'b0000000, rs2_p, rs1_p, 3'b111, rs1_p,
                                      rvc_pkg::OPC_OP};  // C.AND
            endcase
          end
        endcase
      end
      3'b101: begin  // C.J, no link
        o_exp.instr = jal_word;
      end
      3'b110: begin  // C.BEQZ
        o_exp.instr = br_word;
      end
      default: begin  // C.BNEZ
        o_exp.instr = br_word;
        o_exp.instr[14:12] = 3'b001;
      end
    endcase
  end

endmodule : rvc_quadrant1

// File: hdl/rvc_quadrant0.sv
// Quadrant-0 expander, combinational
// Assumes parcel bits 1:0 are already known to be 00
// Only the RV32 subset ADDI4SPN/LW/SW is legal here

`timescale 1ns/10ps

module rvc_quadrant0 (
  input  rvc_pkg::rvc_parcel_t i_parcel,
  output rvc_pkg::rvc_exp_t    o_exp
);

  rvc_pkg::rv_funct3_t funct3;
  rvc_pkg::rv_reg_t    rd_p;      // rd' maps to x8..x15
  rvc_pkg::rv_reg_t    rs1_p;
  rvc_pkg::rv_reg_t    rs2_p;     // Same bits as rd'
  rvc_pkg::rv_imm12_t  imm_4spn;  // nzuimm scaled by 4
  rvc_pkg::rv_imm12_t  imm_lwsw;  // uimm scaled by 4

  assign funct3 = i_parcel[15:13];
  assign rd_p   = {2'b01, i_parcel[4:2]};
  assign rs1_p  = {2'b01, i_parcel[9:7]};
  assign rs2_p  = {2'b01, i_parcel[4:2]};

  // nzuimm[5:4|9:6|2|3] sits in bits 12:5
  assign imm_4spn = {2'b00, i_parcel[10:7], i_parcel[12:11],
                     i_parcel[5], i_parcel[6], 2'b00};

  // uimm[5:3] in 12:10, uimm[2] in 6, uimm[6] in 5
  assign imm_lwsw = {5'b0, i_parcel[5], i_parcel[12:10], i_parcel[6], 2'b00};

  always_comb begin
    o_exp.instr   = '0;
    o_exp.illegal = 1'b0;
    case (funct3)
      3'b000: begin  // C.ADDI4SPN
        o_exp.instr = {imm_4spn, rvc_pkg::REG_SP, 3'b000, rd_p, rvc_pkg::OPC_OP_IMM};
        o_exp.illegal = (imm_4spn == '0);  // All-zero parcel lands here too
      end
      3'b010: begin  // C.LW
        o_exp.instr = {imm_lwsw, rs1_p, 3'b010, rd_p, rvc_pkg::OPC_LOAD};
      end
      3'b110: begin  // C.SW, S-type split of the offset
        o_exp.instr = {imm_lwsw[11:5], rs2_p, rs1_p, 3'b010,
                       imm_lwsw[4:0], rvc_pkg::OPC_STORE};
      end
      default: begin
        // FLD/FSD/FLW/FSW and reserved slots, none supported
        o_exp.illegal = 1'b1;
      end
    endcase
  end

endmodule : rvc_quadrant0

// File: hdl/rvc_pkg.sv
// Shared types and constants for the RV32C decompressor
// RV32 only, so RV64/RV128 encodings are treated as illegal
// Expansion word is don't-care whenever the illegal bit is set

package rvc_pkg;

  // ======================================
  // Basic vector types
  // ======================================
  typedef logic [15:0] rvc_parcel_t;  // Compressed parcel
  typedef logic [31:0] rv_instr_t;    // Full RV32 instruction
  typedef logic [6:0]  rv_opcode_t;   // Major opcode, bits 6:0
  typedef logic [4:0]  rv_reg_t;      // Register specifier
  typedef logic [11:0] rv_imm12_t;    // I/S-type immediate field
  typedef logic [2:0]  rv_funct3_t;   // funct3 of both formats

  // ======================================
  // RV32 major opcodes
  // ======================================
  localparam rv_opcode_t OPC_LUI    = 7'b0110111;
  localparam rv_opcode_t OPC_JAL    = 7'b1101111;
  localparam rv_opcode_t OPC_JALR   = 7'b1100111;
  localparam rv_opcode_t OPC_BRANCH = 7'b1100011;
  localparam rv_opcode_t OPC_LOAD   = 7'b0000011;
  localparam rv_opcode_t OPC_STORE  = 7'b0100011;
  localparam rv_opcode_t OPC_OP_IMM = 7'b0010011;
  localparam rv_opcode_t OPC_OP     = 7'b0110011;

  // Fixed register numbers used by implicit operands
  localparam rv_reg_t REG_ZERO = 5'd0;  // x0
  localparam rv_reg_t REG_RA   = 5'd1;  // Link register
  localparam rv_reg_t REG_SP   = 5'd2;  // Stack pointer

  // EBREAK has no operands, so one constant word
  localparam rv_instr_t INSTR_EBREAK = 32'h0010_0073;

  // ======================================
  // Quadrant codes, parcel bits 1:0
  // ======================================
  localparam logic [1:0] QUAD_C0   = 2'b00;  // Wide imm, loads/stores
  localparam logic [1:0] QUAD_C1   = 2'b01;  // Control flow, arithmetic
  localparam logic [1:0] QUAD_C2   = 2'b10;  // SP-relative, reg moves
  localparam logic [1:0] QUAD_FULL = 2'b11;  // Not compressed

  // ======================================
  // Result structs
  // ======================================

  // One quadrant decoder's answer
  typedef struct packed {
    rv_instr_t instr;    // Expanded word
    logic      illegal;  // Reserved or invalid encoding
  } rvc_exp_t;

  // Registered output word, 34 bits
  typedef struct packed {
    rv_instr_t instr;          // Expansion or zero-extended passthrough
    logic      is_compressed;  // Parcel was in quadrant 0..2
    logic      illegal;        // Expansion is unspecified when set
  } rvc_out_t;

endpackage : rvc_pkg
